// File: rtl/lsu_pkg.sv
////////////////////
// lsu package
// shared widths, enums and structs for the load/store unit
////////////////////

package lsu_pkg;

  parameter int XLEN = 32;  // data and address width

  ////////////////////
  // enums
  ////////////////////

  // access size, as carried with every request
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  // how the upper bits of a load get filled
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // zero fill
    EXT_SIGN = 2'b01,  // copy of the top bit of the selected value
    EXT_ONES = 2'b10   // all ones
  } lsu_ext_e;

  ////////////////////
  // structs
  ////////////////////

  // request from the EX stage
  typedef struct packed {
    logic            we;         // 1: store, 0: load
    lsu_size_e       size;
    lsu_ext_e        ext;
    logic            use_incr;   // address is a + b instead of a
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] wdata;      // store data, low bytes first
  } lsu_req_t;

  // bus address phase
  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic              we;
    logic [XLEN/8-1:0] be;       // one bit per byte lane
    logic [XLEN-1:0]   wdata;    // already rotated onto the lanes
  } bus_req_t;

  // kept per outstanding access until its response arrives
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    lsu_ext_e  ext;
    logic [1:0] offset;          // byte offset inside the word
  } lsu_ctrl_t;

endpackage

// File: rtl/lsu_req_decode.sv
////////////////////
// lsu request decode
// address generation, byte enables, store data rotation
// and the control record kept for the response
////////////////////

`timescale 1ns/1ps

module lsu_req_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ex_valid_i,  // only used to qualify the alignment check
  input  lsu_pkg::lsu_req_t    ex_req_i,
  output lsu_pkg::bus_req_t    bus_o,
  output lsu_pkg::lsu_ctrl_t   ctrl_o
);

  localparam int XLEN = lsu_pkg::XLEN;

  logic [XLEN-1:0]   addr;        // effective address
  logic [1:0]        offset;      // low address bits
  logic [XLEN/8-1:0] be;
  logic [XLEN-1:0]   wdata_rot;   // store data moved onto its lanes
  logic              misaligned;

  ////////////////////
  // address
  ////////////////////

  assign addr   = ex_req_i.use_incr ? (ex_req_i.operand_a + ex_req_i.operand_b)
                                    : ex_req_i.operand_a;
  assign offset = addr[1:0];

  ////////////////////
  // byte enables and store data
  ////////////////////

  // accesses are naturally aligned, so a plain shift never wraps
  always_comb begin
    unique case (ex_req_i.size)
      lsu_pkg::SIZE_WORD: be = '1;                                    // all lanes
      lsu_pkg::SIZE_HALF: be = (XLEN/8)'(4'b0011) << offset;          // two lanes
      default:            be = (XLEN/8)'(4'b0001) << offset;          // byte
    endcase
  end

  // rotate left by offset bytes so byte 0 of wdata lands in the first enabled lane
  always_comb begin
    unique case (offset)
      2'b00: wdata_rot = ex_req_i.wdata;
      2'b01: wdata_rot = {ex_req_i.wdata[XLEN-9:0],  ex_req_i.wdata[XLEN-1:XLEN-8]};
      2'b10: wdata_rot = {ex_req_i.wdata[XLEN-17:0], ex_req_i.wdata[XLEN-1:XLEN-16]};
      default: wdata_rot = {ex_req_i.wdata[XLEN-25:0], ex_req_i.wdata[XLEN-1:XLEN-24]};
    endcase
  end

  assign bus_o.addr  = addr;
  assign bus_o.we    = ex_req_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata_rot;

  // record for the load aligner
  assign ctrl_o.we     = ex_req_i.we;
  assign ctrl_o.size   = ex_req_i.size;
  assign ctrl_o.ext    = ex_req_i.ext;
  assign ctrl_o.offset = offset;

  ////////////////////
  // alignment check
  ////////////////////

  always_comb begin
    unique case (ex_req_i.size)
      lsu_pkg::SIZE_WORD: misaligned = (offset != 2'b00);
      lsu_pkg::SIZE_HALF: misaligned = offset[0];  // halfword must sit on an even byte
      default:            misaligned = 1'b0;
    endcase
  end

  // the EX stage must never hand over a request that straddles a word
  a_aligned_access: assert property (
    @(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> !misaligned
  ) else $error("misaligned access at address %h", addr);

endmodule

// File: rtl/lsu_trans_tracker.sv
////////////////////
// lsu transaction tracker
// issues bus requests, counts outstanding accesses and
// queues their control records until the response returns
////////////////////

`timescale 1ns/1ps

module lsu_trans_tracker #(
  parameter int DEPTH = 2  // max outstanding transactions
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ex_valid_i,
  input  lsu_pkg::bus_req_t  bus_i,
  input  lsu_pkg::lsu_ctrl_t ctrl_i,
  input  logic               bus_gnt_i,
  input  logic               bus_rvalid_i,
  output logic               bus_req_o,
  output lsu_pkg::bus_req_t  bus_o,
  output logic               ex_ready_o,
  output logic               busy_o,
  output logic               resp_valid_o,
  output lsu_pkg::lsu_ctrl_t head_ctrl_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [CNT_W-1:0]   cnt_q;                // outstanding transactions
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  lsu_pkg::lsu_ctrl_t ctrl_mem [DEPTH];     // in-order control queue
  logic               push;                 // address phase done
  logic               pop;                  // response consumed

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // request and handshake
  ////////////////////

  assign bus_req_o    = ex_valid_i && (cnt_q < CNT_W'(DEPTH));
  assign bus_o        = bus_i;                          // held stable by EX until grant
  assign push         = bus_req_o && bus_gnt_i;
  assign pop          = bus_rvalid_i;
  assign ex_ready_o   = !ex_valid_i || push;           // accept on the granting edge
  assign busy_o       = (cnt_q != '0) || bus_req_o;
  assign resp_valid_o = pop;
  assign head_ctrl_o  = ctrl_mem[rd_ptr_q];            // oldest access

  ////////////////////
  // counter and pointers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // idle, or one in and one out
      endcase
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      ctrl_mem[wr_ptr_q] <= ctrl_i;
    end
  end

  // count stays within the queue depth
  a_cnt_bound: assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= CNT_W'(DEPTH)
  ) else $error("outstanding count %0d above DEPTH", cnt_q);

  // bus must not answer something that was never granted
  a_no_spurious_rvalid: assert property (
    @(posedge clk) disable iff (!rst_n) bus_rvalid_i |-> (cnt_q != '0)
  ) else $error("rvalid with no outstanding transaction");

  a_addr_phase_known: assert property (
    @(posedge clk) disable iff (!rst_n) bus_req_o |-> !$isunknown(bus_o)
  ) else $error("unknown address phase while requesting");

endmodule

// File: rtl/lsu_load_align.sv
////////////////////
// lsu load aligner
// picks the byte, halfword or word out of the read data
// and extends it as recorded for the access
////////////////////

`timescale 1ns/1ps

module lsu_load_align (
  input  logic                     resp_valid_i,
  input  lsu_pkg::lsu_ctrl_t       head_ctrl_i,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata_i,
  output logic                     load_valid_o,
  output logic [lsu_pkg::XLEN-1:0] load_data_o
);

  localparam int XLEN = lsu_pkg::XLEN;

  logic [7:0]      rdata_b;     // selected byte
  logic [15:0]     rdata_h;     // selected halfword
  logic            fill_b;      // upper fill bit for byte loads
  logic            fill_h;      // upper fill bit for halfword loads
  logic [XLEN-1:0] rdata_b_ext;
  logic [XLEN-1:0] rdata_h_ext;

  ////////////////////
  // lane select
  ////////////////////

  always_comb begin
    unique case (head_ctrl_i.offset)
      2'b00:   rdata_b = bus_rdata_i[7:0];
      2'b01:   rdata_b = bus_rdata_i[15:8];
      2'b10:   rdata_b = bus_rdata_i[23:16];
      default: rdata_b = bus_rdata_i[31:24];
    endcase
  end

  // aligned halfwords only live at offset 0 or 2
  assign rdata_h = head_ctrl_i.offset[1] ? bus_rdata_i[31:16] : bus_rdata_i[15:0];

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    unique case (head_ctrl_i.ext)
      lsu_pkg::EXT_SIGN: begin
        fill_b = rdata_b[7];
        fill_h = rdata_h[15];
      end
      lsu_pkg::EXT_ONES: begin
        fill_b = 1'b1;
        fill_h = 1'b1;
      end
      default: begin  // zero extension
        fill_b = 1'b0;
        fill_h = 1'b0;
      end
    endcase
  end

  assign rdata_b_ext = {{(XLEN-8){fill_b}}, rdata_b};
  assign rdata_h_ext = {{(XLEN-16){fill_h}}, rdata_h};

  // final size mux
  always_comb begin
    unique case (head_ctrl_i.size)
      lsu_pkg::SIZE_WORD: load_data_o = bus_rdata_i;  // full word, nothing to fill
      lsu_pkg::SIZE_HALF: load_data_o = rdata_h_ext;
      default:            load_data_o = rdata_b_ext;
    endcase
  end

  // stores get their response too, but nothing goes back to the core
  assign load_valid_o = resp_valid_i && !head_ctrl_i.we;

endmodule

// File: rtl/lsu_top.sv
////////////////////
// lsu top
// data memory load/store unit: decode, tracking, load align
////////////////////

`timescale 1ns/1ps

module lsu_top #(
  parameter int DEPTH = 2  // max outstanding bus transactions
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // EX side
  input  logic                     ex_valid_i,
  input  lsu_pkg::lsu_req_t        ex_req_i,
  output logic                     ex_ready_o,
  // bus address phase
  output logic                     bus_req_o,
  input  logic                     bus_gnt_i,
  output lsu_pkg::bus_req_t        bus_o,
  // bus response phase
  input  logic                     bus_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata_i,
  // result
  output logic                     load_valid_o,
  output logic [lsu_pkg::XLEN-1:0] load_data_o,
  output logic                     busy_o
);

  lsu_pkg::bus_req_t  dec_bus;     // decoded address phase
  lsu_pkg::lsu_ctrl_t dec_ctrl;    // record for the current request
  lsu_pkg::lsu_ctrl_t head_ctrl;   // record of the oldest outstanding access
  logic               resp_valid;

  lsu_req_decode u_req_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid_i (ex_valid_i),
    .ex_req_i   (ex_req_i),
    .bus_o      (dec_bus),
    .ctrl_o     (dec_ctrl)
  );

  lsu_trans_tracker #(
    .DEPTH (DEPTH)
  ) u_trans_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .bus_i        (dec_bus),
    .ctrl_i       (dec_ctrl),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_req_o    (bus_req_o),
    .bus_o        (bus_o),
    .ex_ready_o   (ex_ready_o),
    .busy_o       (busy_o),
    .resp_valid_o (resp_valid),
    .head_ctrl_o  (head_ctrl)
  );

  lsu_load_align u_load_align (
    .resp_valid_i (resp_valid),
    .head_ctrl_i  (head_ctrl),
    .bus_rdata_i  (bus_rdata_i),
    .load_valid_o (load_valid_o),
    .load_data_o  (load_data_o)
  );

endmodule

// File: verification/lsu_checker.sv
////////////////////
// lsu checker
// watches the lsu ports, keeps a byte image of the memory
// window and compares every access against it
////////////////////

`timescale 1ns/1ps

module lsu_checker #(
  parameter int DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ex_valid_i,
  input  lsu_pkg::lsu_req_t        ex_req_i,
  input  logic                     ex_ready_i,
  input  logic                     bus_req_i,
  input  logic                     bus_gnt_i,
  input  lsu_pkg::bus_req_t        bus_i,
  input  logic                     bus_rvalid_i,
  input  logic                     load_valid_i,
  input  logic [lsu_pkg::XLEN-1:0] load_data_i,
  input  logic                     busy_i,
  input  logic                     done_i,      // stimulus finished, drain checks run
  output int                       err_cnt_o,   // failed tests
  output logic                     report_o     // summary printed
);

  logic [7:0]        img [64];     // byte image of the 16-word window
  logic [31:0]       exp_q [$];    // expected load results, oldest first
  logic              kind_q [$];   // we of each outstanding access
  int                outstanding;  // granted minus responded
  logic              held_q;       // last cycle requested without grant
  lsu_pkg::bus_req_t held_bus;
  int                errs [6];
  int                checks [6];
  logic              rst_seen;     // one edge already taken in reset
  logic              reset_done;
  int                drain_cyc;

  // same fill rule as the bus model, every address bit matters
  function automatic logic [7:0] init_byte(input logic [5:0] a);
    return 8'(int'(a) * 37 + 91);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "reset";
      1:       return "store encoding";
      2:       return "load extension";
      3:       return "ordering";
      4:       return "back-pressure";
      default: return "drain";
    endcase
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  // bytes at the address, extended as the request asks
  function automatic logic [31:0] load_model(input logic [5:0] a, input lsu_pkg::lsu_size_e size,
                                             input lsu_pkg::lsu_ext_e ext);
    logic [15:0] half;
    logic        fill;
    case (size)
      lsu_pkg::SIZE_WORD: return {img[a+3], img[a+2], img[a+1], img[a]};
      lsu_pkg::SIZE_HALF: begin
        half = {img[a+1], img[a]};
        fill = (ext == lsu_pkg::EXT_ONES) || (ext == lsu_pkg::EXT_SIGN && half[15]);
        return {{16{fill}}, half};
      end
      default: begin
        fill = (ext == lsu_pkg::EXT_ONES) || (ext == lsu_pkg::EXT_SIGN && img[a][7]);
        return {{24{fill}}, img[a]};
      end
    endcase
  endfunction

  task automatic check_val(input int t, input string sig, input logic [31:0] got,
                           input logic [31:0] exp);
    checks[t]++;
    if (got !== exp) begin
      errs[t]++;
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_cond(input int t, input bit ok, input string what);
    checks[t]++;
    if (!ok) begin
      errs[t]++;
      $display("ERROR at %0d ns: %s", $time, what);
    end
  endtask

  // a test with no checks at all counts as failed
  task automatic print_test(input int t);
    $display("test %0d %s: %s (%0d checks, %0d errors)", t, test_name(t),
             (errs[t] == 0 && checks[t] > 0) ? "PASS" : "FAIL", checks[t], errs[t]);
  endtask

  initial begin : init
    int i;
    for (i = 0; i < 64; i++) img[i] = init_byte(6'(i));
    for (i = 0; i < 6; i++) begin
      errs[i]   = 0;
      checks[i] = 0;
    end
    outstanding = 0;
    held_q      = 1'b0;
    rst_seen    = 1'b0;
    reset_done  = 1'b0;
    drain_cyc   = 0;
    err_cnt_o   = 0;
    report_o    = 1'b0;
  end

  ////////////////////
  // per cycle checks
  ////////////////////

  always @(posedge clk) begin : watch
    logic [31:0] exp_addr;
    logic [3:0]  exp_be;
    int          off;
    int          lane;
    int          failed;
    logic        kind;
    logic        exp_req;
    if (!rst_n || !reset_done) begin  // in reset and the first cycle after it
      if (rst_seen) begin  // flops have seen a clock edge in reset by now
        check_val(0, "bus_req_o", bus_req_i, 0);
        check_val(0, "load_valid_o", load_valid_i, 0);
        check_val(0, "busy_o", busy_i, 0);
      end
      rst_seen = 1'b1;
      if (rst_n) begin
        reset_done = 1'b1;
        print_test(0);
      end
    end else begin
      // back-pressure and handshake
      exp_req = ex_valid_i && (outstanding < DEPTH);  // a free slot and a request
      check_cond(4, outstanding <= DEPTH, "more than DEPTH transactions outstanding");
      if (outstanding == DEPTH)
        check_cond(4, !bus_req_i, "bus request raised with DEPTH accesses outstanding");
      if (held_q)
        check_cond(4, bus_req_i && bus_i === held_bus, "address phase changed before grant");
      check_val(4, "bus_req_o", bus_req_i, exp_req);
      check_val(4, "ex_ready_o", ex_ready_i, !ex_valid_i || (exp_req && bus_gnt_i));
      check_val(5, "busy_o", busy_i, (outstanding != 0) || exp_req);
      held_q   = bus_req_i && !bus_gnt_i;
      held_bus = bus_i;

      // response side, oldest access first
      if (bus_rvalid_i) begin
        if (kind_q.size() == 0) begin
          check_cond(3, 1'b0, "bus response with no outstanding access");
        end else begin
          kind = kind_q.pop_front();
          outstanding--;
          check_val(3, "load_valid_o", load_valid_i, !kind);  // stores give no pulse
          if (!kind) check_val(2, "load_data_o", load_data_i, exp_q.pop_front());
        end
      end else begin
        check_val(3, "load_valid_o", load_valid_i, 0);
      end

      // address phase
      if (bus_req_i && bus_gnt_i) begin
        exp_addr = ex_req_i.use_incr ? ex_req_i.operand_a + ex_req_i.operand_b
                                     : ex_req_i.operand_a;
        off      = int'(exp_addr[1:0]);
        check_val(1, "bus_o.addr", bus_i.addr, exp_addr);
        check_val(1, "bus_o.we", bus_i.we, ex_req_i.we);
        kind_q.push_back(ex_req_i.we);
        outstanding++;
        if (ex_req_i.we) begin
          case (ex_req_i.size)
            lsu_pkg::SIZE_WORD: exp_be = 4'b1111;
            lsu_pkg::SIZE_HALF: exp_be = 4'b0011 << off;
            default:            exp_be = 4'b0001 << off;
          endcase
          check_val(1, "bus_o.be", bus_i.be, exp_be);
          for (lane = 0; lane < 4; lane++) begin
            if (exp_be[lane]) begin  // lane carries wdata byte lane - off
              check_val(1, "bus_o.wdata", bus_i.wdata[8*lane +: 8],
                        ex_req_i.wdata[8*(lane-off) +: 8]);
              img[{exp_addr[5:2], 2'(lane)}] = bus_i.wdata[8*lane +: 8];
            end
          end
        end else begin
          exp_q.push_back(load_model(exp_addr[5:0], ex_req_i.size, ex_req_i.ext));
        end
      end

      // drain window, nothing may move
      if (done_i) begin
        check_val(5, "busy_o", busy_i, 0);
        check_val(5, "bus_req_o", bus_req_i, 0);
        check_cond(5, outstanding == 0 && exp_q.size() == 0,
                   "accesses still outstanding after the last response");
        drain_cyc++;
        if (drain_cyc == 4) begin
          failed = 0;
          for (lane = 1; lane < 6; lane++) print_test(lane);
          for (lane = 0; lane < 6; lane++)
            if (errs[lane] != 0 || checks[lane] == 0) failed++;
          $display("summary: 6 tests, %0d passed, %0d failed", 6 - failed, failed);
          err_cnt_o = failed;
          report_o  = 1'b1;
        end
      end
    end
  end

endmodule

// File: verification/lsu_tb.sv
////////////////////
// lsu testbench
// random aligned loads and stores against a memory model
// with random grant and response latency
////////////////////

`timescale 1ns/1ps

module lsu_tb;

  localparam int DEPTH    = 2;
  localparam int NUM_OPS  = 120;
  localparam int TIMEOUT  = NUM_OPS * 8 + 100;  // cycles

  logic                     clk;
  logic                     rst_n;
  logic                     ex_valid;
  lsu_pkg::lsu_req_t        ex_req;
  logic                     ex_ready;
  logic                     bus_req;
  logic                     bus_gnt;
  lsu_pkg::bus_req_t        bus;
  logic                     bus_rvalid;
  logic [lsu_pkg::XLEN-1:0] bus_rdata;
  logic                     load_valid;
  logic [lsu_pkg::XLEN-1:0] load_data;
  logic                     busy;

  logic [31:0] lfsr;
  logic [31:0] mem [16];        // bus side memory, 16 words
  logic [31:0] pend_data [$];   // read data of granted accesses, in order
  int          pend_due [$];    // cycle at which each response may go out
  int          cyc;
  int          op_cnt;          // requests raised so far
  int          next_lat;        // latency for a grant at the coming edge
  logic        acc_q;           // request accepted at the last edge
  logic        done;
  int          err_cnt;
  logic        report;

  function automatic logic [7:0] init_byte(input logic [5:0] a);
    return 8'(int'(a) * 37 + 91);
  endfunction

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic make_request();
    logic [31:0] r;
    logic [31:0] addr;
    take_bits(1, r);
    ex_req.we = r[0];
    take_bits(2, r);
    case (r[1:0])
      2'd0:    ex_req.size = lsu_pkg::SIZE_WORD;
      2'd1:    ex_req.size = lsu_pkg::SIZE_HALF;
      default: ex_req.size = lsu_pkg::SIZE_BYTE;
    endcase
    take_bits(2, r);
    case (r[1:0])
      2'd0:    ex_req.ext = lsu_pkg::EXT_ZERO;
      2'd1:    ex_req.ext = lsu_pkg::EXT_SIGN;
      default: ex_req.ext = lsu_pkg::EXT_ONES;
    endcase
    take_bits(1, r);
    ex_req.use_incr = r[0];
    take_bits(6, r);
    addr = 32'h0000_4000 | r[5:0];  // word index and byte offset
    if (ex_req.size == lsu_pkg::SIZE_WORD) addr[1:0] = 2'b00;
    if (ex_req.size == lsu_pkg::SIZE_HALF) addr[0] = 1'b0;
    take_bits(8, r);
    ex_req.operand_b = {24'b0, r[7:0]};
    ex_req.operand_a = ex_req.use_incr ? addr - ex_req.operand_b : addr;
    take_bits(32, r);
    ex_req.wdata = r;
  endtask

  // one falling edge worth of input changes
  task automatic drive_cycle();
    logic [31:0] r;
    if (!ex_valid || acc_q) begin  // EX holds the request until accepted
      ex_valid = 1'b0;
      if (op_cnt < NUM_OPS) begin
        take_bits(2, r);
        if (r[1:0] != 2'b00) begin
          make_request();
          ex_valid = 1'b1;
          op_cnt++;
        end
      end
    end
    take_bits(2, r);
    bus_gnt = (r[1:0] != 2'b00);
    take_bits(2, r);
    next_lat = int'(r[1:0]) + 1;  // 1 to 4 cycles
    bus_rvalid = 1'b0;
    if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      bus_rvalid = 1'b1;
      bus_rdata  = pend_data[0];
    end
    done = (op_cnt == NUM_OPS) && !ex_valid && (pend_due.size() == 0);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : main
    int i;
    lfsr       = 32'h209c;
    rst_n      = 1'b0;
    ex_valid   = 1'b0;
    ex_req     = '0;
    bus_gnt    = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    cyc        = 0;
    op_cnt     = 0;
    next_lat   = 1;
    acc_q      = 1'b0;
    done       = 1'b0;
    for (i = 0; i < 16; i++)
      mem[i] = {init_byte({i[3:0], 2'd3}), init_byte({i[3:0], 2'd2}),
                init_byte({i[3:0], 2'd1}), init_byte({i[3:0], 2'd0})};
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);  // one quiet cycle after reset
    while (!done) begin
      drive_cycle();
      @(negedge clk);
    end
    wait (report);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  ////////////////////
  // bus model
  ////////////////////

  always @(posedge clk) begin : bus_model
    int          i;
    logic [31:0] junk_d;
    int          junk_t;
    if (rst_n) begin
      acc_q = ex_valid && ex_ready;
      if (bus_rvalid) begin  // response consumed
        junk_d = pend_data.pop_front();
        junk_t = pend_due.pop_front();
      end
      if (bus_req && bus_gnt) begin
        pend_data.push_back(mem[bus.addr[5:2]]);  // read data fixed in grant order
        pend_due.push_back(cyc + next_lat);
        if (bus.we)
          for (i = 0; i < 4; i++)
            if (bus.be[i]) mem[bus.addr[5:2]][8*i +: 8] = bus.wdata[8*i +: 8];
      end
    end
    cyc++;
    if (cyc >= TIMEOUT) begin
      $display("timeout: run still going after %0d cycles", cyc);
      $display("Test failures found");
      $finish;
    end
  end

  lsu_top #(
    .DEPTH (DEPTH)
  ) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid),
    .ex_req_i     (ex_req),
    .ex_ready_o   (ex_ready),
    .bus_req_o    (bus_req),
    .bus_gnt_i    (bus_gnt),
    .bus_o        (bus),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .load_valid_o (load_valid),
    .load_data_o  (load_data),
    .busy_o       (busy)
  );

  lsu_checker #(
    .DEPTH (DEPTH)
  ) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid),
    .ex_req_i     (ex_req),
    .ex_ready_i   (ex_ready),
    .bus_req_i    (bus_req),
    .bus_gnt_i    (bus_gnt),
    .bus_i        (bus),
    .bus_rvalid_i (bus_rvalid),
    .load_valid_i (load_valid),
    .load_data_i  (load_data),
    .busy_i       (busy),
    .done_i       (done),
    .err_cnt_o    (err_cnt),
    .report_o     (report)
  );

endmodule

// File: compile.f
rtl/lsu_pkg.sv
rtl/lsu_req_decode.sv
rtl/lsu_trans_tracker.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv
